// File: logic/com_uplink_pkg.sv
package com_uplink_pkg;

    // block types known to the request side
    typedef enum logic [3:0] {
        BTYPE_INFO = 4'h1,
        BTYPE_DATA = 4'hE
    } btype_e;

    // one-hot request states
    typedef enum logic [4:0] {
        IDLE = 5'b00001,
        WAIT = 5'b00010,
        TAKE = 5'b00100,
        WORK = 5'b01000,
        DONE = 5'b10000
    } send_state_e;

    // receive buffer region map
    localparam logic [14:0] RXA_INIT = 15'h0000;
    localparam logic [14:0] RXA_INFO = 15'h0100;
    localparam logic [14:0] RXA_DAT0 = 15'h1000;
    localparam logic [14:0] RXA_DAT1 = 15'h2200;
    localparam logic [14:0] RXA_DAT2 = 15'h3400;
    localparam logic [14:0] RXA_DAT3 = 15'h4600;
    localparam logic [14:0] RXA_DAT4 = 15'h5800;
    localparam logic [14:0] RXA_DAT5 = 15'h6A00;

    // info blocks are fixed size and data blocks carry a fixed preamble part
    localparam logic [11:0] LEN_INFO = 12'd14;
    localparam logic [11:0] LEN_PART = 12'd36;

    typedef struct packed {
        btype_e      btype;
        logic [3:0]  didx;
        logic [11:0] dlen;
    } send_req_t;

    typedef struct packed {
        logic [14:0] start;
        logic [12:0] len;
    } send_desc_t;

endpackage

// File: logic/eth_frame_pkg.sv
package eth_frame_pkg;

    localparam int HDR_BYTES = 8;
    localparam logic [7:0] SOF_MARK = 8'hA5;

    typedef enum logic [2:0] {
        T_IDLE,
        T_HDR,
        T_PAY,
        T_END,
        T_WAIT
    } tx_state_e;

    // byte 0 sits in the top bits and multi-byte fields are big-endian
    typedef struct packed {
        logic [7:0]  sof;
        logic [3:0]  btype;
        logic [3:0]  didx;
        logic [15:0] len;
        logic [15:0] start;
        logic [7:0]  seq;
        logic [7:0]  csum;
    } frame_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       last;
    } tx_byte_t;

endpackage

// File: logic/rxa_buffer_ram.sv
module rxa_buffer_ram #(
    parameter int ADDR_W = 15
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [7:0]        wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [7:0]        rd_data
);

    logic [7:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read returns old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: logic/com_send.sv
module com_send (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fs,
    input  com_uplink_pkg::send_req_t  req,
    input  logic                     fd_eth,
    output logic                     fs_eth,
    output logic                     fd,
    output logic                     take,
    output com_uplink_pkg::send_desc_t desc
);

    com_uplink_pkg::send_state_e state;
    com_uplink_pkg::send_state_e state_nxt;
    com_uplink_pkg::send_desc_t  desc_nxt;

    assign fs_eth = (state == com_uplink_pkg::WORK);
    assign fd     = (state == com_uplink_pkg::DONE);
    assign take   = (state == com_uplink_pkg::TAKE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= com_uplink_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            com_uplink_pkg::IDLE: state_nxt = com_uplink_pkg::WAIT;
            com_uplink_pkg::WAIT: state_nxt = fs ? com_uplink_pkg::TAKE : com_uplink_pkg::WAIT;
            com_uplink_pkg::TAKE: state_nxt = com_uplink_pkg::WORK;
            com_uplink_pkg::WORK: state_nxt = fd_eth ? com_uplink_pkg::DONE : com_uplink_pkg::WORK;
            // hold done until the controller drops its request
            com_uplink_pkg::DONE: state_nxt = fs ? com_uplink_pkg::DONE : com_uplink_pkg::IDLE;
            default:              state_nxt = com_uplink_pkg::IDLE;
        endcase
    end

    // buffer window for the pending request
    always_comb begin
        desc_nxt = '0;
        case (req.btype)
            com_uplink_pkg::BTYPE_INFO: begin
                desc_nxt.start = com_uplink_pkg::RXA_INFO;
                desc_nxt.len   = {1'b0, com_uplink_pkg::LEN_INFO};
            end
            com_uplink_pkg::BTYPE_DATA: begin
                desc_nxt.len = {1'b0, req.dlen} + {1'b0, com_uplink_pkg::LEN_PART};
                case (req.didx)
                    4'd0:    desc_nxt.start = com_uplink_pkg::RXA_DAT0;
                    4'd1:    desc_nxt.start = com_uplink_pkg::RXA_DAT1;
                    4'd2:    desc_nxt.start = com_uplink_pkg::RXA_DAT2;
                    4'd3:    desc_nxt.start = com_uplink_pkg::RXA_DAT3;
                    4'd4:    desc_nxt.start = com_uplink_pkg::RXA_DAT4;
                    4'd5:    desc_nxt.start = com_uplink_pkg::RXA_DAT5;
                    default: desc_nxt.start = com_uplink_pkg::RXA_INIT;
                endcase
            end
            default: begin
                // unknown types send a header only
                desc_nxt.start = com_uplink_pkg::RXA_INIT;
                desc_nxt.len   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            desc <= '0;
        end else if (state == com_uplink_pkg::TAKE) begin
            desc <= desc_nxt;
        end else if (state == com_uplink_pkg::DONE) begin
            desc <= '0;
        end
    end

endmodule

// File: logic/frame_hdr_gen.sv
module frame_hdr_gen #(
    parameter logic [7:0] SEQ_INIT = 8'd0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       take,
    input  com_uplink_pkg::send_req_t  req,
    input  com_uplink_pkg::send_desc_t desc,
    output eth_frame_pkg::frame_hdr_t  hdr
);

    logic [7:0] seq_cnt;
    logic [7:0] seq_q;
    logic [3:0] btype_q;
    logic [3:0] didx_q;

    eth_frame_pkg::frame_hdr_t hdr_raw;
    logic [eth_frame_pkg::HDR_BYTES-1:0][7:0] raw_b;
    logic [7:0] csum;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq_cnt <= SEQ_INIT;
        end else if (take) begin
            seq_cnt <= seq_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            btype_q <= req.btype;
            didx_q  <= req.didx;
            seq_q   <= seq_cnt;
        end
    end

    // desc is already registered by the time the header is read
    always_comb begin
        hdr_raw.sof   = eth_frame_pkg::SOF_MARK;
        hdr_raw.btype = btype_q;
        hdr_raw.didx  = didx_q;
        hdr_raw.len   = {3'b000, desc.len};
        hdr_raw.start = {1'b0, desc.start};
        hdr_raw.seq   = seq_q;
        hdr_raw.csum  = '0;
    end

    assign raw_b = hdr_raw;

    // raw_b[0] is the checksum slot itself
    always_comb begin
        csum = '0;
        for (int i = 1; i < eth_frame_pkg::HDR_BYTES; i++) begin
            csum = csum ^ raw_b[i];
        end
    end

    always_comb begin
        hdr      = hdr_raw;
        hdr.csum = csum;
    end

endmodule

// File: logic/eth_frame_tx.sv
module eth_frame_tx #(
    parameter int ADDR_W = 15
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fs_eth,
    input  eth_frame_pkg::frame_hdr_t  hdr,
    input  com_uplink_pkg::send_desc_t desc,
    output logic [ADDR_W-1:0]          rd_addr,
    input  logic [7:0]                 rd_data,
    output eth_frame_pkg::tx_byte_t    tx,
    output logic                       fd_eth
);

    localparam int CNT_W = $clog2(eth_frame_pkg::HDR_BYTES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(eth_frame_pkg::HDR_BYTES - 1);

    eth_frame_pkg::tx_state_e state;
    eth_frame_pkg::tx_state_e state_nxt;

    logic [CNT_W-1:0] cnt;
    logic [12:0] rem;
    logic [ADDR_W-1:0] ptr;
    logic [eth_frame_pkg::HDR_BYTES-1:0][7:0] hdr_b;
    logic hdr_end;
    logic pay_end;

    assign hdr_b = hdr;

    assign hdr_end = (state == eth_frame_pkg::T_HDR) && (cnt == CNT_LAST);
    assign pay_end = (state == eth_frame_pkg::T_PAY) && (rem == 13'd1);

    always_comb begin
        case (state)
            eth_frame_pkg::T_IDLE: begin
                state_nxt = fs_eth ? eth_frame_pkg::T_HDR : eth_frame_pkg::T_IDLE;
            end
            eth_frame_pkg::T_HDR: begin
                if (!hdr_end) begin
                    state_nxt = eth_frame_pkg::T_HDR;
                end else if (rem == '0) begin
                    state_nxt = eth_frame_pkg::T_END;
                end else begin
                    state_nxt = eth_frame_pkg::T_PAY;
                end
            end
            eth_frame_pkg::T_PAY: begin
                state_nxt = pay_end ? eth_frame_pkg::T_END : eth_frame_pkg::T_PAY;
            end
            eth_frame_pkg::T_END: state_nxt = eth_frame_pkg::T_WAIT;
            // request side drops fs_eth one cycle after done
            eth_frame_pkg::T_WAIT: begin
                state_nxt = fs_eth ? eth_frame_pkg::T_WAIT : eth_frame_pkg::T_IDLE;
            end
            default: state_nxt = eth_frame_pkg::T_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= eth_frame_pkg::T_IDLE;
            cnt   <= '0;
            rem   <= '0;
            ptr   <= '0;
        end else begin
            state <= state_nxt;
            if (state == eth_frame_pkg::T_IDLE) begin
                cnt <= '0;
                rem <= desc.len;
                ptr <= ADDR_W'(desc.start);
            end
            if (state == eth_frame_pkg::T_HDR) begin
                cnt <= cnt + 1'b1;
            end
            if (state == eth_frame_pkg::T_PAY) begin
                rem <= rem - 13'd1;
            end
            // address of payload byte 0 goes out with header byte 7
            if (hdr_end || state == eth_frame_pkg::T_PAY) begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    assign rd_addr = ptr;

    always_comb begin
        tx.valid = (state == eth_frame_pkg::T_HDR) || (state == eth_frame_pkg::T_PAY);
        tx.last  = (hdr_end && rem == '0) || pay_end;
        if (state == eth_frame_pkg::T_PAY) begin
            tx.data = rd_data;
        end else begin
            tx.data = hdr_b[CNT_LAST - cnt];
        end
    end

    assign fd_eth = (state == eth_frame_pkg::T_END);

endmodule

// File: logic/com_uplink_top.sv
module com_uplink_top #(
    parameter int         ADDR_W   = 15,
    parameter logic [7:0] SEQ_INIT = 8'd0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fs,
    input  com_uplink_pkg::send_req_t req,
    output logic                      fd,
    input  logic                      wr_en,
    input  logic [ADDR_W-1:0]         wr_addr,
    input  logic [7:0]                wr_data,
    output eth_frame_pkg::tx_byte_t   tx
);

    logic fs_eth;
    logic fd_eth;
    logic take;
    com_uplink_pkg::send_desc_t desc;
    eth_frame_pkg::frame_hdr_t  hdr;
    logic [ADDR_W-1:0] rd_addr;
    logic [7:0] rd_data;

    com_send u_com_send (
        .clk    (clk),
        .rst    (rst),
        .fs     (fs),
        .req    (req),
        .fd_eth (fd_eth),
        .fs_eth (fs_eth),
        .fd     (fd),
        .take   (take),
        .desc   (desc)
    );

    frame_hdr_gen #(
        .SEQ_INIT (SEQ_INIT)
    ) u_frame_hdr_gen (
        .clk  (clk),
        .rst  (rst),
        .take (take),
        .req  (req),
        .desc (desc),
        .hdr  (hdr)
    );

    eth_frame_tx #(
        .ADDR_W (ADDR_W)
    ) u_eth_frame_tx (
        .clk     (clk),
        .rst     (rst),
        .fs_eth  (fs_eth),
        .hdr     (hdr),
        .desc    (desc),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .tx      (tx),
        .fd_eth  (fd_eth)
    );

    rxa_buffer_ram #(
        .ADDR_W (ADDR_W)
    ) u_rxa_buffer_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: sim/tb_com_uplink.sv
module tb_com_uplink;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQ = 40;
    localparam int TIMEOUT_CYCLES = NUM_REQ * (8 + 291 + 16) + 33000;

    logic clk = 1'b0;
    logic rst;
    logic fs;
    com_uplink_pkg::send_req_t req;
    logic fd;
    logic wr_en;
    logic [14:0] wr_addr;
    logic [7:0] wr_data;
    eth_frame_pkg::tx_byte_t tx;

    logic [7:0] buf_copy [32768];
    logic [31:0] rng_state = 32'h17ce;
    int cycle_cnt = 0;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    com_uplink_top #(
        .ADDR_W   (15),
        .SEQ_INIT (8'd0)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .fs      (fs),
        .req     (req),
        .fd      (fd),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .tx      (tx)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift_next();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // info windows are fixed and data windows add the 36-byte part
    function automatic com_uplink_pkg::send_desc_t model_desc(
        input com_uplink_pkg::send_req_t r
    );
        com_uplink_pkg::send_desc_t d;
        d.start = com_uplink_pkg::RXA_INIT;
        d.len   = '0;
        if (r.btype == com_uplink_pkg::BTYPE_INFO) begin
            d.start = com_uplink_pkg::RXA_INFO;
            d.len   = 13'd14;
        end else if (r.btype == com_uplink_pkg::BTYPE_DATA) begin
            d.len = {1'b0, r.dlen} + 13'd36;
            case (r.didx)
                4'd0: d.start = com_uplink_pkg::RXA_DAT0;
                4'd1: d.start = com_uplink_pkg::RXA_DAT1;
                4'd2: d.start = com_uplink_pkg::RXA_DAT2;
                4'd3: d.start = com_uplink_pkg::RXA_DAT3;
                4'd4: d.start = com_uplink_pkg::RXA_DAT4;
                4'd5: d.start = com_uplink_pkg::RXA_DAT5;
                default: d.start = com_uplink_pkg::RXA_INIT;
            endcase
        end
        return d;
    endfunction

    function automatic eth_frame_pkg::frame_hdr_t model_hdr(
        input com_uplink_pkg::send_req_t  r,
        input com_uplink_pkg::send_desc_t d,
        input logic [7:0]                 seq
    );
        logic [0:7][7:0] b;
        b[0] = 8'hA5;
        b[1] = {r.btype, r.didx};
        b[2] = {3'b000, d.len[12:8]};
        b[3] = d.len[7:0];
        b[4] = {1'b0, d.start[14:8]};
        b[5] = d.start[7:0];
        b[6] = seq;
        b[7] = '0;
        for (int i = 0; i < 7; i++) begin
            b[7] = b[7] ^ b[i];
        end
        return b;
    endfunction

    task automatic check_byte(input string name, input eth_frame_pkg::tx_byte_t exp,
                              input eth_frame_pkg::tx_byte_t act);
        if (act !== exp) begin
            $display("ERR %s exp data %h valid %h last %h, act data %h valid %h last %h",
                     name, exp.data, exp.valid, exp.last, act.data, act.valid, act.last);
            err_cnt++;
        end
    endtask

    task automatic check_len(input string name, input logic [12:0] exp, input logic [12:0] act);
        if (act !== exp) begin
            $display("ERR %s exp %h act %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_hdr(input string name, input eth_frame_pkg::frame_hdr_t exp,
                             input eth_frame_pkg::frame_hdr_t act);
        if (act !== exp) begin
            $display("ERR %s exp %h act %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // fd and tx.valid must stay quiet while the buffer fills
    task automatic preload_buffer();
        logic [31:0] r;
        bit active_seen;
        active_seen = 1'b0;
        for (int a = 0; a < 32768; a++) begin
            r = xorshift_next();
            wr_en   = 1'b1;
            wr_addr = a[14:0];
            wr_data = r[7:0];
            buf_copy[a[14:0]] = r[7:0];
            @(negedge clk);
            if (fd || tx.valid) begin
                active_seen = 1'b1;
            end
        end
        wr_en = 1'b0;
        if (active_seen) begin
            $display("fd or tx.valid went high before the first request");
            err_cnt++;
        end
        $display("idle check during preload %s", active_seen ? "mismatch" : "ok");
    endtask

    task automatic run_request(input int idx);
        com_uplink_pkg::send_req_t  r;
        com_uplink_pkg::send_desc_t d;
        eth_frame_pkg::frame_hdr_t  eh;
        eth_frame_pkg::tx_byte_t    eb;
        logic [63:0] eh_bits;
        logic [63:0] got_bits;
        logic [31:0] rnd;
        logic [3:0]  code;
        logic [12:0] pay_len;
        int errs_before;
        int lat;
        int n;
        int k;
        bit stop;
        bit extra;
        errs_before = err_cnt;
        rnd = xorshift_next();
        case (rnd[1:0])
            2'd0: code = com_uplink_pkg::BTYPE_INFO;
            2'd3: begin
                code = 4'(xorshift_next());
                while (code == 4'h1 || code == 4'hE) begin
                    code = 4'(xorshift_next());
                end
            end
            default: code = com_uplink_pkg::BTYPE_DATA;
        endcase
        r.btype = com_uplink_pkg::btype_e'(code);
        r.didx  = {1'b0, rnd[4:2]};
        r.dlen  = {4'h0, rnd[15:8]};
        d = model_desc(r);
        eh = model_hdr(r, d, idx[7:0]);
        eh_bits = eh;

        // fs rises in cycle 1 while com_send sits in WAIT
        fs  = 1'b1;
        req = r;
        lat = 1;
        while (!tx.valid && lat < 12) begin
            @(negedge clk);
            lat++;
        end
        if (!tx.valid) begin
            $display("request %0d: first byte never came", idx);
            err_cnt++;
        end else if (lat != 4) begin
            $display("request %0d: first byte in cycle %0d after fs, expected 4", idx, lat);
            err_cnt++;
        end

        n = 0;
        stop = 1'b0;
        got_bits = '0;
        while (!stop) begin
            if (!tx.valid) begin
                $display("request %0d: frame ended early after %0d bytes", idx, n);
                err_cnt++;
                stop = 1'b1;
            end else begin
                eb.valid = 1'b1;
                eb.last  = (n == 8 + d.len - 1);
                if (n < 8) begin
                    eb.data  = eh_bits[63 - 8 * n -: 8];
                    got_bits = {got_bits[55:0], tx.data};
                end else begin
                    eb.data = buf_copy[15'(d.start + n - 8)];
                end
                check_byte("tx", eb, tx);
                n++;
                if (tx.last || n >= 8 + 300) begin
                    stop = 1'b1;
                end else begin
                    @(negedge clk);
                end
            end
        end
        check_hdr("hdr", eh, got_bits);
        pay_len = (n > 8) ? 13'(n - 8) : 13'd0;
        check_len("payload length", d.len, pay_len);

        // fd is expected two cycles after tx.last
        k = 0;
        extra = 1'b0;
        while (!fd && k < 8) begin
            @(negedge clk);
            k++;
            if (tx.valid) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            $display("request %0d: byte sent after tx.last", idx);
            err_cnt++;
        end
        if (!fd) begin
            $display("request %0d: fd never rose", idx);
            err_cnt++;
        end else if (k != 2) begin
            $display("request %0d: fd rose %0d cycles after tx.last, expected 2", idx, k);
            err_cnt++;
        end

        repeat (rnd[17:16]) begin
            @(negedge clk);
            if (!fd) begin
                $display("request %0d: fd fell while fs was still high", idx);
                err_cnt++;
            end
        end
        fs  = 1'b0;
        req = '0;
        @(negedge clk);
        if (fd) begin
            $display("request %0d: fd stayed high after fs fell", idx);
            err_cnt++;
        end
        repeat (3) begin
            @(negedge clk);
            if (fd || tx.valid) begin
                $display("request %0d: output active between requests", idx);
                err_cnt++;
            end
        end

        if (err_cnt == errs_before) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("request %0d: btype %h didx %0d len %0d seq %0d %s", idx, code, r.didx,
                 d.len, idx, (err_cnt == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst     = 1'b1;
        fs      = 1'b0;
        req     = '0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        preload_buffer();
        repeat (3) @(negedge clk);
        for (int i = 0; i < NUM_REQ; i++) begin
            run_request(i);
        end
        $display("requests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: com_uplink.f
logic/com_uplink_pkg.sv
logic/eth_frame_pkg.sv
logic/rxa_buffer_ram.sv
logic/com_send.sv
logic/frame_hdr_gen.sv
logic/eth_frame_tx.sv
logic/com_uplink_top.sv
sim/tb_com_uplink.sv

// File: Bender.yml
package:
  name: com_uplink

sources:
  # packages first, then leaf modules, then the top level
  - logic/com_uplink_pkg.sv
  - logic/eth_frame_pkg.sv
  - logic/rxa_buffer_ram.sv
  - logic/com_send.sv
  - logic/frame_hdr_gen.sv
  - logic/eth_frame_tx.sv
  - logic/com_uplink_top.sv
  - target: simulation
    files:
      - sim/tb_com_uplink.sv
